// ==== udp_echo.f ====
+incdir+include
source/udp_echo_pkg.sv
source/hex_segment_decoder.sv
source/status_display.sv
source/payload_fifo.sv
source/udp_port_filter.sv
source/udp_echo_top.sv
dv/udp_echo_asserts.sv
dv/tb_udp_echo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UDP echo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f udp_echo.f --top-module tb_udp_echo -o tb_udp_echo
./obj_dir/tb_udp_echo > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    exit 1
fi

// ==== dv/tb_udp_echo.sv ====
/*
 * Directed testbench for the UDP echo application layer.
 * Drives parsed headers and payload bytes into the DUT and checks the
 * reply header, the echoed payload, the LEDs and the digits.
 */
`timescale 1ns/1ns
`include "udp_echo_defs.svh"

module tb_udp_echo
    import udp_echo_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                    clk;
    logic                    rst;
    udp_hdr_t                rx_hdr;
    logic                    rx_hdr_valid;
    logic                    rx_hdr_ready;
    udp_hdr_t                reply_hdr;
    logic                    reply_hdr_valid;
    logic                    reply_hdr_ready;
    axis_byte_t              rx_payload;
    logic                    rx_payload_valid;
    logic                    rx_payload_ready;
    axis_byte_t              tx_payload;
    logic                    tx_payload_valid;
    logic                    tx_payload_ready;
    logic [7:0]              led;
    seg7_t [`HEX_DIGITS-1:0] hex;

    // Frame being sent and beats collected at the output
    logic [7:0] frame_data[$];
    logic       frame_user[$];
    axis_byte_t out_beats[$];

    int       sent_beats;
    int       reply_count = 0;
    int       tx_valid_cycles = 0;
    udp_hdr_t last_reply = '0;

    udp_echo_top i_udp_echo_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Mid-cycle monitor of reply headers and output activity
    always @(negedge clk) begin
        if (!rst) begin
            if (reply_hdr_valid && reply_hdr_ready) begin
                reply_count++;
                last_reply = reply_hdr;
            end
            if (tx_payload_valid) begin
                tx_valid_cycles++;
            end
        end
    end

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    // Active-low hex digit patterns, segment a in bit 0
    function automatic seg7_t seg_pattern(input logic [3:0] nibble);
        seg7_t table_low [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
        return table_low[nibble];
    endfunction

    task automatic fill_frame(input int n);
        frame_data.delete();
        frame_user.delete();
        repeat (n) begin
            frame_data.push_back(8'($urandom));
            frame_user.push_back(1'($urandom));
        end
    endtask

    task automatic send_header(input udp_hdr_t hdr);
        int waited;
        waited = 0;
        rx_hdr = hdr;
        rx_hdr_valid = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                timeout_fail("rx_hdr_ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_frame(input udp_hdr_t hdr);
        int waited;
        int i;
        sent_beats = 0;
        send_header(hdr);
        for (i = 0; i < frame_data.size(); i++) begin
            rx_payload.data = frame_data[i];
            rx_payload.last = (i == frame_data.size() - 1);
            rx_payload.user = frame_user[i];
            rx_payload_valid = 1'b1;
            waited = 0;
            @(negedge clk);
            while (!rx_payload_ready) begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    timeout_fail("rx_payload_ready");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            sent_beats++;
        end
        rx_payload_valid = 1'b0;
    endtask

    // Accepts output beats until the closing one
    task automatic collect_frame();
        int  waited;
        logic done;
        out_beats.delete();
        done = 1'b0;
        @(posedge clk);
        #2;
        tx_payload_ready = 1'b1;
        while (!done) begin
            waited = 0;
            @(negedge clk);
            while (!tx_payload_valid) begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    timeout_fail("tx_payload_valid");
                end
                @(negedge clk);
            end
            out_beats.push_back(tx_payload);
            done = tx_payload.last;
        end
        @(posedge clk);
        #2;
        tx_payload_ready = 1'b0;
    endtask

    task automatic compare_payload();
        int i;
        check_equal(128'(out_beats.size()), 128'(frame_data.size()), "payload length");
        for (i = 0; i < out_beats.size(); i++) begin
            check_equal(128'(out_beats[i].data), 128'(frame_data[i]), $sformatf("byte %0d", i));
            check_equal(128'(out_beats[i].user), 128'(frame_user[i]), $sformatf("user %0d", i));
            check_equal(128'(out_beats[i].last), 128'(i == out_beats.size() - 1),
                        $sformatf("last %0d", i));
        end
    endtask

    function automatic udp_hdr_t random_hdr(input logic [15:0] dst_port);
        udp_hdr_t hdr;
        hdr.src_ip   = 32'($urandom);
        hdr.dst_ip   = `LOCAL_IP;
        hdr.src_port = 16'($urandom);
        hdr.dst_port = dst_port;
        hdr.length   = 16'($urandom);
        return hdr;
    endfunction

    task automatic echo_frame(input udp_hdr_t hdr, input int n);
        udp_hdr_t expected;
        int       replies_before;
        expected.src_ip   = `LOCAL_IP;
        expected.dst_ip   = hdr.src_ip;
        expected.src_port = hdr.dst_port;
        expected.dst_port = hdr.src_port;
        expected.length   = hdr.length;
        replies_before = reply_count;
        fill_frame(n);
        fork
            send_frame(hdr);
            collect_frame();
        join
        check_equal(128'(reply_count - replies_before), 128'(1), "reply header count");
        check_equal(128'(last_reply), 128'(expected), "reply header");
        compare_payload();
    endtask

    task automatic test_reset_state();
        int i;
        check_equal(128'(reply_hdr_valid), 128'(0), "reply_hdr_valid after reset");
        check_equal(128'(rx_hdr_ready), 128'(0), "rx_hdr_ready after reset");
        check_equal(128'(tx_payload_valid), 128'(0), "tx_payload_valid after reset");
        check_equal(128'(rx_payload_ready), 128'(0), "rx_payload_ready after reset");
        check_equal(128'(led), 128'(0), "led after reset");
        for (i = 0; i < `HEX_DIGITS; i++) begin
            check_equal(128'(hex[i]), 128'(7'h40), $sformatf("digit %0d after reset", i));
        end
    endtask

    // Reply header is held back for a few cycles before it is taken
    task automatic test_echo();
        reply_hdr_ready = 1'b0;
        fork
            echo_frame(random_hdr(`UDP_LISTEN_PORT), 8 + int'($urandom % 13));
            begin
                repeat (3) @(negedge clk);
                check_equal(128'(reply_hdr_valid), 128'(1), "reply_hdr_valid while stalled");
                check_equal(128'(rx_hdr_ready), 128'(0), "rx_hdr_ready while reply stalled");
                @(posedge clk);
                #2;
                reply_hdr_ready = 1'b1;
            end
        join
    endtask

    task automatic test_drop();
        int replies_before;
        int valid_before;
        replies_before = reply_count;
        valid_before = tx_valid_cycles;
        fill_frame(12);
        send_frame(random_hdr(`UDP_LISTEN_PORT + 16'd1));
        repeat (3) @(posedge clk);
        #2;
        check_equal(128'(rx_payload_ready), 128'(0), "payload ready after dropped frame");
        check_equal(128'(reply_count), 128'(replies_before), "reply for dropped frame");
        check_equal(128'(tx_valid_cycles), 128'(valid_before), "output for dropped frame");
    endtask

    task automatic test_backpressure();
        int waited;
        udp_hdr_t hdr;
        hdr = random_hdr(`UDP_LISTEN_PORT);
        fill_frame(100);
        fork
            send_frame(hdr);
            begin
                waited = 0;
                while (sent_beats < `PAYLOAD_FIFO_DEPTH) begin
                    waited++;
                    if (waited > TIMEOUT_CYCLES) begin
                        timeout_fail("FIFO to fill");
                    end
                    @(negedge clk);
                end
                // Full FIFO must hold off the sender
                repeat (4) @(negedge clk);
                check_equal(128'(rx_payload_ready), 128'(0), "rx_payload_ready when full");
                check_equal(128'(sent_beats), 128'(`PAYLOAD_FIFO_DEPTH), "beats before stall");
                collect_frame();
            end
        join
        compare_payload();
    endtask

    task automatic test_status();
        udp_hdr_t hdr;
        int       i;
        echo_frame(random_hdr(`UDP_LISTEN_PORT), 5);
        hdr = random_hdr(`UDP_LISTEN_PORT);
        echo_frame(hdr, 7);
        check_equal(128'(led), 128'(frame_data[0]), "led first byte");
        for (i = 0; i < `HEX_DIGITS; i++) begin
            check_equal(128'(hex[i]), 128'(seg_pattern(hdr.src_ip[4*i +: 4])),
                        $sformatf("digit %0d", i));
        end
    endtask

    initial begin
        void'($urandom(64));
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        reply_hdr_ready  = 1'b1;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_payload_ready = 1'b0;
        sent_beats       = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset_state();
        test_echo();
        test_drop();
        test_backpressure();
        test_status();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== dv/udp_echo_asserts.sv ====
/*
 * Concurrent checks on the port filter handshakes and frame phase.
 * Bound into udp_port_filter at the end of this file.
 */
`timescale 1ns/1ns

module udp_echo_asserts
    import udp_echo_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       rx_hdr_valid,
    input logic       rx_hdr_ready,
    input axis_byte_t rx_payload,
    input logic       rx_payload_valid,
    input logic       rx_payload_ready,
    input udp_hdr_t   reply_hdr,
    input logic       reply_hdr_valid,
    input logic       reply_hdr_ready,
    input logic       fifo_in_valid
);

    // Frame phase rebuilt from the handshakes alone
    logic in_frame;
    logic frame_echoed;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame     <= 1'b0;
            frame_echoed <= 1'b0;
        end else if (!in_frame) begin
            if (rx_hdr_valid && rx_hdr_ready) begin
                in_frame     <= 1'b1;
                frame_echoed <= reply_hdr_valid;
            end
        end else if (rx_payload_valid && rx_payload_ready && rx_payload.last) begin
            in_frame <= 1'b0;
        end
    end

    // No payload between frames
    a_idle_payload_blocked: assert property (@(posedge clk) disable iff (rst)
        !in_frame |-> !rx_payload_ready)
        else $error("rx_payload_ready high between frames");

    // Offered reply header is held until taken
    a_reply_held: assert property (@(posedge clk) disable iff (rst)
        (reply_hdr_valid && !reply_hdr_ready) |=> (reply_hdr_valid && $stable(reply_hdr)))
        else $error("reply header dropped or changed before transfer");

    a_fifo_only_in_echo: assert property (@(posedge clk) disable iff (rst)
        fifo_in_valid |-> (in_frame && frame_echoed))
        else $error("fifo_in_valid outside an echoed frame");

endmodule

bind udp_port_filter udp_echo_asserts i_udp_echo_asserts (
    .clk              (clk),
    .rst              (rst),
    .rx_hdr_valid     (rx_hdr_valid),
    .rx_hdr_ready     (rx_hdr_ready),
    .rx_payload       (rx_payload),
    .rx_payload_valid (rx_payload_valid),
    .rx_payload_ready (rx_payload_ready),
    .reply_hdr        (reply_hdr),
    .reply_hdr_valid  (reply_hdr_valid),
    .reply_hdr_ready  (reply_hdr_ready),
    .fifo_in_valid    (fifo_in_valid)
);

// ==== source/udp_echo_top.sv ====
/*
 * Application layer of the UDP echo node.
 * Takes parsed UDP frames, echoes those sent to the listening port
 * and shows the first payload byte and the reply address on the board.
 */
`timescale 1ns/1ns
`include "udp_echo_defs.svh"

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    input  udp_hdr_t                     rx_hdr,
    input  logic                         rx_hdr_valid,
    output logic                         rx_hdr_ready,

    output udp_hdr_t                     reply_hdr,
    output logic                         reply_hdr_valid,
    input  logic                         reply_hdr_ready,

    input  axis_byte_t                   rx_payload,
    input  logic                         rx_payload_valid,
    output logic                         rx_payload_ready,

    output axis_byte_t                   tx_payload,
    output logic                         tx_payload_valid,
    input  logic                         tx_payload_ready,

    output logic [7:0]                   led,
    output seg7_t [`HEX_DIGITS-1:0]      hex
);

    // Filter to FIFO payload stream
    axis_byte_t fifo_in;
    logic       fifo_in_valid;
    logic       fifo_in_ready;

    udp_port_filter i_udp_port_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .reply_hdr        (reply_hdr),
        .reply_hdr_valid  (reply_hdr_valid),
        .reply_hdr_ready  (reply_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    payload_fifo #(
        .DEPTH(`PAYLOAD_FIFO_DEPTH)
    ) i_payload_fifo (
        .clk              (clk),
        .rst              (rst),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready)
    );

    status_display i_status_display (
        .clk              (clk),
        .rst              (rst),
        .reply_hdr        (reply_hdr),
        .reply_hdr_valid  (reply_hdr_valid),
        .reply_hdr_ready  (reply_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led),
        .hex              (hex)
    );

endmodule

// ==== source/udp_port_filter.sv ====
/*
 * Port filter for parsed UDP frames.
 * Frames to the listening port get a swapped reply header and their
 * payload is passed on to the FIFO; all other frames are drained.
 */
`timescale 1ns/1ns
`include "udp_echo_defs.svh"

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Received header
    input  udp_hdr_t   rx_hdr,
    input  logic       rx_hdr_valid,
    output logic       rx_hdr_ready,

    // Reply header towards the stack
    output udp_hdr_t   reply_hdr,
    output logic       reply_hdr_valid,
    input  logic       reply_hdr_ready,

    // Received payload
    input  axis_byte_t rx_payload,
    input  logic       rx_payload_valid,
    output logic       rx_payload_ready,

    // Payload into the echo FIFO
    output axis_byte_t fifo_in,
    output logic       fifo_in_valid,
    input  logic       fifo_in_ready
);

    filter_state_t state;
    filter_state_t state_next;

    logic port_match;
    logic hdr_accept;
    logic payload_accept;

    assign port_match = (rx_hdr.dst_port == `UDP_LISTEN_PORT);

    // Reply swaps addresses and ports, source is always this node
    always_comb begin
        reply_hdr.src_ip   = `LOCAL_IP;
        reply_hdr.dst_ip   = rx_hdr.src_ip;
        reply_hdr.src_port = rx_hdr.dst_port;
        reply_hdr.dst_port = rx_hdr.src_port;
        reply_hdr.length   = rx_hdr.length;
    end

    // Headers are only taken between frames
    assign reply_hdr_valid = (state == IDLE) && rx_hdr_valid && port_match;
    assign rx_hdr_ready    = (state == IDLE) && rx_hdr_valid &&
                             (!port_match || reply_hdr_ready);
    assign hdr_accept      = rx_hdr_valid && rx_hdr_ready;

    // Payload steering
    assign fifo_in       = rx_payload;
    assign fifo_in_valid = (state == ECHO) && rx_payload_valid;

    always_comb begin
        case (state)
            ECHO:    rx_payload_ready = fifo_in_ready;
            DROP:    rx_payload_ready = 1'b1;
            default: rx_payload_ready = 1'b0;
        endcase
    end

    assign payload_accept = rx_payload_valid && rx_payload_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_accept) begin
                    state_next = port_match ? ECHO : DROP;
                end
            end
            ECHO, DROP: begin
                // Back to header phase on the closing byte
                if (payload_accept && rx_payload.last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== source/payload_fifo.sv ====
/*
 * Synchronous FIFO for payload bytes with a registered output stage.
 * Holds up to DEPTH beats in total, including the output register.
 */
`timescale 1ns/1ns
`include "udp_echo_defs.svh"

module payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int DEPTH = `PAYLOAD_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst,

    input  axis_byte_t fifo_in,
    input  logic       fifo_in_valid,
    output logic       fifo_in_ready,

    output axis_byte_t tx_payload,
    output logic       tx_payload_valid,
    input  logic       tx_payload_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    axis_byte_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // Beats held, output register included
    logic [AW:0]   count;
    logic [AW:0]   mem_count;

    logic wr_en;
    logic rd_en;
    logic load;
    logic from_mem;
    logic bypass;

    assign fifo_in_ready = (count != FULL_COUNT);
    assign wr_en         = fifo_in_valid && fifo_in_ready;
    assign rd_en         = tx_payload_valid && tx_payload_ready;

    assign mem_count = count - {{AW{1'b0}}, tx_payload_valid};

    // Output register takes a new beat when empty or being drained
    assign load     = !tx_payload_valid || rd_en;
    assign from_mem = load && (mem_count != '0);
    // Empty memory, incoming beat goes straight to the output
    assign bypass   = load && (mem_count == '0) && wr_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            count            <= '0;
            tx_payload_valid <= 1'b0;
        end else begin
            if (wr_en && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (from_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (load) begin
                tx_payload_valid <= from_mem || bypass;
            end
            count <= count + {{AW{1'b0}}, wr_en} - {{AW{1'b0}}, rd_en};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !bypass) begin
            mem[wr_ptr] <= fifo_in;
        end
        if (from_mem) begin
            tx_payload <= mem[rd_ptr];
        end else if (bypass) begin
            tx_payload <= fifo_in;
        end
    end

endmodule

// ==== source/status_display.sv ====
/*
 * Board status for the echo path.
 * The first byte of each echoed payload goes to the LEDs and the last
 * reply destination IP is shown on the seven-segment digits.
 */
`timescale 1ns/1ns
`include "udp_echo_defs.svh"

module status_display
    import udp_echo_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  udp_hdr_t                reply_hdr,
    input  logic                    reply_hdr_valid,
    input  logic                    reply_hdr_ready,

    input  axis_byte_t              tx_payload,
    input  logic                    tx_payload_valid,
    input  logic                    tx_payload_ready,

    output logic [7:0]              led,
    output seg7_t [`HEX_DIGITS-1:0] hex
);

    // Next output beat opens a frame
    logic        sof;
    logic [31:0] dest_ip;

    always_ff @(posedge clk) begin
        if (rst) begin
            sof     <= 1'b1;
            led     <= '0;
            dest_ip <= '0;
        end else begin
            if (tx_payload_valid && tx_payload_ready) begin
                if (sof) begin
                    led <= tx_payload.data;
                end
                sof <= tx_payload.last;
            end
            if (reply_hdr_valid && reply_hdr_ready) begin
                dest_ip <= reply_hdr.dst_ip;
            end
        end
    end

    // Digit i shows nibble i of the address
    for (genvar i = 0; i < `HEX_DIGITS; i++) begin : g_digit
        hex_segment_decoder i_hex_segment_decoder (
            .nibble (dest_ip[4*i +: 4]),
            .seg    (hex[i])
        );
    end

endmodule

// ==== source/hex_segment_decoder.sv ====
/*
 * Hex nibble to seven-segment pattern, active low outputs.
 */
`timescale 1ns/1ns

module hex_segment_decoder
    import udp_echo_pkg::*;
(
    input  logic [3:0] nibble,
    output seg7_t      seg
);

    // Lit segments, gfedcba order
    seg7_t lit;

    always_comb begin
        case (nibble)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
    end

    assign seg = ~lit;

endmodule

// ==== source/udp_echo_pkg.sv ====
/*
 * Types shared by the UDP echo modules.
 * Import with a wildcard in the module header.
 */
package udp_echo_pkg;

    // Parsed UDP header, also used for the reply
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One payload byte on a valid/ready stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_byte_t;

    // Per-frame routing of the payload
    typedef enum logic [1:0] {
        IDLE,
        ECHO,
        DROP
    } filter_state_t;

    // Bit 0 is segment a, bit 6 is segment g, active low
    typedef logic [6:0] seg7_t;

endpackage

// ==== include/udp_echo_defs.svh ====
/*
 * Build constants for the UDP echo design.
 * Include this wherever the listening port, local address,
 * FIFO depth or digit count is needed.
 */
`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// Destination port that gets echoed
`define UDP_LISTEN_PORT 16'd1234

// 192.168.1.128
`define LOCAL_IP 32'hC0A8_0180

// Payload FIFO entries, must be a power of two
`define PAYLOAD_FIFO_DEPTH 64

// Seven-segment digits on the board, one nibble each
`define HEX_DIGITS 8

`endif
